/* sim.f */
rtl/cpu_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_alu.sv
rtl/cpu_shift.sv
rtl/cpu_sequencer.sv
rtl/cpu_datapath.sv
rtl/cpu_core.sv
verification/cpu_sva.sv
verification/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_tb -f sim.f -o cpu_sim

output=$(./obj_dir/cpu_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

/* verification/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int clock_period    = 4;
    localparam int reset_cycles    = 4;
    localparam int run_count       = 6;   // One program run per test
    localparam int run_cycle_limit = 600; // Longest program with stalls fits well inside
    localparam int watchdog_ns     = (run_count * (run_cycle_limit + reset_cycles) + 100)
                                     * clock_period;

    // 6502 start address location and zero-page high byte
    localparam logic [15:0] vector_address = 16'hfffc;
    localparam logic [7:0]  zero_page_high = 8'h00;

    // 6502 opcodes used by the programs
    localparam logic [7:0] lda_imm = 8'ha9;
    localparam logic [7:0] lda_zp  = 8'ha5;
    localparam logic [7:0] ldx_imm = 8'ha2;
    localparam logic [7:0] ldx_zp  = 8'ha6;
    localparam logic [7:0] ldy_imm = 8'ha0;
    localparam logic [7:0] ldy_zp  = 8'ha4;
    localparam logic [7:0] sta_zp  = 8'h85;
    localparam logic [7:0] stx_zp  = 8'h86;
    localparam logic [7:0] sty_zp  = 8'h84;
    localparam logic [7:0] adc_imm = 8'h69;
    localparam logic [7:0] clc     = 8'h18;
    localparam logic [7:0] sec     = 8'h38;
    localparam logic [7:0] inx     = 8'he8;
    localparam logic [7:0] iny     = 8'hc8;
    localparam logic [7:0] dex     = 8'hca;
    localparam logic [7:0] dey     = 8'h88;
    localparam logic [7:0] tax     = 8'haa;
    localparam logic [7:0] tay     = 8'ha8;
    localparam logic [7:0] txa     = 8'h8a;
    localparam logic [7:0] tya     = 8'h98;
    localparam logic [7:0] jmp_abs = 8'h4c;

    logic                           clock = 1'b0;
    logic                           reset = 1'b1;
    logic                           enable = 1'b1;
    logic [cpu_pkg::data_width-1:0] data_in;
    logic [cpu_pkg::addr_width-1:0] address;
    logic [cpu_pkg::data_width-1:0] data_out;
    logic                           write_enable;
    logic                           sync;

    logic [7:0]                     mem [0:65535];  // Full 64 KB space
    logic [cpu_pkg::addr_width-1:0] stored_addr[$], exp_addr[$];
    logic [cpu_pkg::data_width-1:0] stored_data[$], exp_data[$];
    logic [cpu_pkg::addr_width-1:0] first_sync;
    logic                           sync_seen;
    logic [15:0]                    prog_ptr;
    logic [31:0]                    rng_state = 32'h5af7;
    int                             mismatch_count = 0;
    int                             other_errors = 0;

    cpu_core dut (
        .clock(clock), .reset(reset), .enable(enable), .data_in(data_in),
        .address(address), .data_out(data_out), .write_enable(write_enable), .sync(sync)
    );

    always #(clock_period / 2) clock = ~clock;

    assign data_in = mem[address];  // Combinational read

    // Memory write port and bus monitor
    always @(posedge clock)
    begin
        if (!reset && enable && write_enable)
        begin
            mem[address] <= data_out;
            stored_addr.push_back(address);
            stored_data.push_back(data_out);
        end
        if (!reset && sync && !sync_seen)
        begin
            first_sync = address;  // First opcode fetch after reset
            sync_seen  = 1'b1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value ^ (value << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [7:0] random_byte();
        rng_state = xorshift(rng_state);
        return rng_state[7:0];
    endfunction

    // Program start somewhere in 1000 to 1FFF clear of zero page and vectors
    function automatic logic [15:0] random_start();
        logic [7:0] high;
        high = random_byte();
        return {4'h1, high[3:0], random_byte()};
    endfunction

    // 8-bit binary ALU rules with carry in the top bit
    function automatic logic [8:0] alu_model(input cpu_pkg::alu_op_e op,
                                             input logic [7:0] a, b, input logic c);
        int sum;
        case (op)
            cpu_pkg::op_ora: return {c, a | b};
            cpu_pkg::op_and: return {c, a & b};
            cpu_pkg::op_eor: return {c, a ^ b};
            cpu_pkg::op_lda: return {c, b};
            cpu_pkg::op_adc:
            begin
                sum = int'(a) + int'(b) + int'(c);
                return {sum > 255, sum[7:0]};
            end
            cpu_pkg::op_sbc:
            begin
                sum = int'(a) - int'(b) - int'(!c);  // Borrow is not carry
                return {sum >= 0, sum[7:0]};
            end
            cpu_pkg::op_cmp: return {a >= b, a};     // A untouched
            default: return {c, a};
        endcase
    endfunction

    // Shift rules where the bit shifted out lands in carry
    function automatic logic [8:0] shift_model(input cpu_pkg::shift_op_e op,
                                               input logic [7:0] a, input logic c);
        case (op)
            cpu_pkg::op_asl: return {a[7], a[6:0], 1'b0};
            cpu_pkg::op_rol: return {a[7], a[6:0], c};
            cpu_pkg::op_lsr: return {a[0], 1'b0, a[7:1]};
            default:         return {a[0], c, a[7:1]};
        endcase
    endfunction

    task automatic compare_byte(input string name,
                                input logic [cpu_pkg::data_width-1:0] expected, actual);
        if (actual !== expected)
        begin
            $display("mismatch in %s: expected %02h, actual %02h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic compare_address(input string name,
                                   input logic [cpu_pkg::addr_width-1:0] expected, actual);
        if (actual !== expected)
        begin
            $display("mismatch in %s: expected %04h, actual %04h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic emit(input logic [7:0] value);
        mem[prog_ptr] <= value;
        prog_ptr = prog_ptr + 16'd1;
    endtask

    task automatic emit_pair(input logic [7:0] op, arg);
        emit(op);
        emit(arg);
    endtask

    // Store to 00xx and record what should appear on the bus
    task automatic emit_store(input logic [7:0] op, low, expected);
        emit_pair(op, low);
        exp_addr.push_back({zero_page_high, low});
        exp_data.push_back(expected);
    endtask

    // Carry comes out as A after LDA #0, ADC #0
    task automatic observe_carry(input logic [7:0] low, input logic carry);
        emit_pair(lda_imm, 8'h00);
        emit_pair(adc_imm, 8'h00);
        emit_store(sta_zp, low, {7'd0, carry});
    endtask

    task automatic begin_program(input logic [15:0] start);
        reset  = 1'b1;
        enable = 1'b1;
        repeat (reset_cycles) @(negedge clock);
        stored_addr.delete();
        stored_data.delete();
        exp_addr.delete();
        exp_data.delete();
        sync_seen = 1'b0;
        mem[vector_address] <= start[7:0];
        mem[vector_address + 16'd1] <= start[15:8];
        prog_ptr = start;
    endtask

    task automatic end_program();
        logic [15:0] here;
        here = prog_ptr;
        emit(jmp_abs);  // Park on a jump to itself
        emit(here[7:0]);
        emit(here[15:8]);
    endtask

    // Release reset, wait for every expected store or the cycle limit
    task automatic run_program(input string name, input logic stall);
        int cycles;
        cycles = 0;
        reset  = 1'b0;
        while (stored_data.size() < exp_data.size() && cycles < run_cycle_limit)
        begin
            @(negedge clock);
            if (stall)
                enable = (random_byte() & 8'h03) != 8'h00;  // Low about one cycle in four
            cycles++;
        end
        enable = 1'b1;
        if (stored_data.size() < exp_data.size())
        begin
            $display("error: %s saw only %0d of %0d stores within %0d cycles",
                     name, stored_data.size(), exp_data.size(), run_cycle_limit);
            other_errors++;
        end
    endtask

    task automatic check_stores(input string name);
        for (int i = 0; i < exp_data.size(); i++)
        begin
            if (i >= stored_data.size())
            begin
                $display("error: %s store %0d never reached the bus", name, i);
                other_errors++;
            end
            else
            begin
                compare_address($sformatf("%s store %0d", name, i), exp_addr[i], stored_addr[i]);
                compare_byte($sformatf("%s store %0d", name, i), exp_data[i], stored_data[i]);
            end
        end
    endtask

    task automatic load_and_store(input logic [7:0] load_op, arg, store_op, low, expected);
        emit_pair(load_op, arg);
        emit_store(store_op, low, expected);
    endtask

    task automatic counter_case(input logic [7:0] load_op, value, op, store_op, low, expected);
        emit_pair(load_op, value);
        emit(op);
        emit_store(store_op, low, expected);
    endtask

    task automatic reset_vector_fetch();
        logic [15:0] start;
        logic [7:0]  value;
        start = random_start();
        value = random_byte();
        begin_program(start);
        load_and_store(lda_imm, value, sta_zp, 8'h80, value);
        end_program();
        run_program("reset_vector", 1'b0);
        compare_address("reset_vector first fetch", start, first_sync);
        check_stores("reset_vector");
    endtask

    task automatic register_loads_stores();
        logic [7:0] v [6];
        begin_program(random_start());
        for (int k = 0; k < 6; k++)
            v[k] = random_byte();
        for (int k = 0; k < 3; k++)
            mem[16'h0010 + 16'(k)] <= v[k + 3];  // Zero-page sources
        load_and_store(lda_imm, v[0], sta_zp, 8'h80, v[0]);
        load_and_store(ldx_imm, v[1], stx_zp, 8'h81, v[1]);
        load_and_store(ldy_imm, v[2], sty_zp, 8'h82, v[2]);
        load_and_store(lda_zp, 8'h10, sta_zp, 8'h83, v[3]);
        load_and_store(ldx_zp, 8'h11, stx_zp, 8'h84, v[4]);
        load_and_store(ldy_zp, 8'h12, sty_zp, 8'h85, v[5]);
        end_program();
        run_program("loads_stores", 1'b0);
        check_stores("loads_stores");
    endtask

    task automatic alu_operations();
        cpu_pkg::alu_op_e op;
        logic [7:0]       a, b, low;
        logic [8:0]       expected;
        begin_program(random_start());
        low = 8'h80;
        for (int k = 0; k < 8; k++)
        begin
            for (int c = 0; c < 2; c++)
            begin
                op = cpu_pkg::alu_op_e'(k[2:0]);
                if (op != cpu_pkg::op_sta)  // STA immediate does not exist
                begin
                    a = random_byte();
                    b = random_byte();
                    expected = alu_model(op, a, b, c[0]);
                    emit(c[0] ? sec : clc);
                    emit_pair(lda_imm, a);
                    emit_pair({k[2:0], 5'b01001}, b);  // Immediate column
                    emit_store(sta_zp, low, expected[7:0]);
                    observe_carry(low + 8'd1, expected[8]);
                    low = low + 8'd2;
                end
            end
        end
        end_program();
        run_program("alu", 1'b0);
        check_stores("alu");
    endtask

    task automatic shifts_and_rotates();
        cpu_pkg::shift_op_e op;
        logic [7:0]         a, low;
        logic [8:0]         expected;
        begin_program(random_start());
        low = 8'h80;
        for (int k = 0; k < 4; k++)
        begin
            for (int c = 0; c < 2; c++)
            begin
                op = cpu_pkg::shift_op_e'(k[1:0]);
                a = random_byte();
                expected = shift_model(op, a, c[0]);
                emit(c[0] ? sec : clc);
                emit_pair(lda_imm, a);
                emit({1'b0, k[1:0], 5'b01010});  // Accumulator form
                emit_store(sta_zp, low, expected[7:0]);
                observe_carry(low + 8'd1, expected[8]);
                low = low + 8'd2;
            end
        end
        end_program();
        run_program("shifts", 1'b0);
        check_stores("shifts");
    endtask

    task automatic counters_and_transfers();
        logic [7:0] r [6];
        begin_program(random_start());
        for (int k = 0; k < 6; k++)
            r[k] = random_byte();
        counter_case(ldx_imm, 8'hff, inx, stx_zp, 8'h80, 8'h00);  // Wraps up
        counter_case(ldy_imm, 8'h00, dey, sty_zp, 8'h81, 8'hff);  // Wraps down
        counter_case(ldx_imm, 8'h00, dex, stx_zp, 8'h82, 8'hff);  // Wraps down
        counter_case(ldy_imm, 8'hff, iny, sty_zp, 8'h83, 8'h00);  // Wraps up
        counter_case(ldx_imm, r[0], dex, stx_zp, 8'h84, r[0] - 8'd1);
        counter_case(ldy_imm, r[1], iny, sty_zp, 8'h85, r[1] + 8'd1);
        counter_case(lda_imm, r[2], tax, stx_zp, 8'h86, r[2]);
        counter_case(lda_imm, r[3], tay, sty_zp, 8'h87, r[3]);
        counter_case(ldx_imm, r[4], txa, sta_zp, 8'h88, r[4]);
        counter_case(ldy_imm, r[5], tya, sta_zp, 8'h89, r[5]);
        end_program();
        run_program("counters", 1'b0);
        check_stores("counters");
    endtask

    // Load, add, store with enable dropping at random
    task automatic stalled_program();
        logic [7:0] a, b;
        logic [8:0] expected;
        begin_program(random_start());
        for (int k = 0; k < 3; k++)
        begin
            a = random_byte();
            b = random_byte();
            expected = alu_model(cpu_pkg::op_adc, a, b, 1'b0);
            mem[16'h0020 + 16'(k)] <= a;
            emit(clc);
            emit_pair(lda_zp, 8'h20 + 8'(k));
            emit_pair(adc_imm, b);
            emit_store(sta_zp, 8'h90 + 8'(2 * k), expected[7:0]);
            observe_carry(8'h91 + 8'(2 * k), expected[8]);
        end
        end_program();
        run_program("stall", 1'b1);
        check_stores("stall");
    endtask

    initial
    begin
        for (int i = 0; i < 65536; i++)
            mem[i[15:0]] <= 8'(i ^ (i >> 8) ^ 32'h5a);  // Pattern over all address bits
        reset_vector_fetch();
        register_loads_stores();
        alu_operations();
        shifts_and_rotates();
        counters_and_transfers();
        stalled_program();
        $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(watchdog_ns);
        $display("error: run did not finish within %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verification/cpu_sva.sv */
`timescale 1ns/1ps

module cpu_sva (
    input logic                           clock,
    input logic                           reset,
    input logic                           enable,
    input logic [cpu_pkg::addr_width-1:0] address,
    input logic                           write_enable,
    input logic                           sync
);

    // Bus goes quiet once a reset edge has been taken
    reset_quiet: assert property (@(posedge clock) reset |=> !write_enable && !sync)
        else $error("write_enable or sync high right after a reset edge");

    // A stalled edge leaves the address where it was
    stall_hold: assert property (@(posedge clock) !reset && !enable |=> $stable(address))
        else $error("address moved across a stalled cycle");

    // Opcode fetch is always a read
    fetch_no_write: assert property (@(posedge clock) !(sync && write_enable))
        else $error("sync and write_enable high in the same cycle");

endmodule

bind cpu_core cpu_sva sva (
    .clock(clock), .reset(reset), .enable(enable),
    .address(address), .write_enable(write_enable), .sync(sync)
);

/* rtl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,        // Global clock enable
    input  logic [cpu_pkg::data_width-1:0] data_in,
    output logic [cpu_pkg::addr_width-1:0] address,
    output logic [cpu_pkg::data_width-1:0] data_out,
    output logic                           write_enable,
    output logic                           sync           // Opcode fetch cycle
);

    logic [cpu_pkg::data_width-1:0] opcode, operand, store_data;
    logic                           execute;
    cpu_pkg::alu_op_e               alu_op;
    cpu_pkg::shift_op_e             shift_op;
    logic                           is_two_cycle, is_zero_page, is_jump, is_store;
    logic                           uses_alu, is_shift, load_a, load_x, load_y;
    logic                           count_x, count_y, count_up, count_down;
    logic                           transfer_from_a, set_carry_direct;

    cpu_sequencer sequencer (
        .clock(clock), .reset(reset), .enable(enable), .data_in(data_in),
        .is_two_cycle(is_two_cycle), .is_zero_page(is_zero_page),
        .is_jump(is_jump), .is_store(is_store), .store_data(store_data),
        .address(address), .data_out(data_out), .write_enable(write_enable),
        .sync(sync), .opcode(opcode), .operand(operand), .execute(execute)
    );

    // Selects follow the opcode register
    cpu_decode decode (
        .opcode(opcode), .alu_op(alu_op), .shift_op(shift_op),
        .is_two_cycle(is_two_cycle), .is_zero_page(is_zero_page),
        .is_jump(is_jump), .is_store(is_store),
        .uses_alu(uses_alu), .is_shift(is_shift),
        .load_a(load_a), .load_x(load_x), .load_y(load_y),
        .count_x(count_x), .count_y(count_y),
        .count_up(count_up), .count_down(count_down),
        .transfer_from_a(transfer_from_a), .set_carry_direct(set_carry_direct)
    );

    cpu_datapath datapath (
        .clock(clock), .reset(reset), .execute(execute),
        .opcode(opcode), .operand(operand),
        .alu_op(alu_op), .shift_op(shift_op),
        .uses_alu(uses_alu), .is_shift(is_shift),
        .load_a(load_a), .load_x(load_x), .load_y(load_y),
        .count_x(count_x), .count_y(count_y),
        .count_up(count_up), .count_down(count_down),
        .transfer_from_a(transfer_from_a), .set_carry_direct(set_carry_direct),
        .store_data(store_data)
    );

endmodule

/* rtl/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           execute,
    input  logic [cpu_pkg::data_width-1:0] opcode,
    input  logic [cpu_pkg::data_width-1:0] operand,
    input  cpu_pkg::alu_op_e               alu_op,
    input  cpu_pkg::shift_op_e             shift_op,
    input  logic                           uses_alu,
    input  logic                           is_shift,
    input  logic                           load_a,
    input  logic                           load_x,
    input  logic                           load_y,
    input  logic                           count_x,
    input  logic                           count_y,
    input  logic                           count_up,
    input  logic                           count_down,
    input  logic                           transfer_from_a,
    input  logic                           set_carry_direct,
    output logic [cpu_pkg::data_width-1:0] store_data
);

    logic [cpu_pkg::data_width-1:0] a_reg, x_reg, y_reg;
    logic                           carry;
    logic [cpu_pkg::data_width-1:0] alu_result, shift_result;
    logic                           alu_carry, shift_carry;
    logic [cpu_pkg::data_width-1:0] count_in, count_out;
    logic [cpu_pkg::data_width-1:0] internal_bus;
    logic                           next_carry;

    cpu_alu alu (
        .a(a_reg), .b(operand), .carry_in(carry), .op(alu_op),
        .result(alu_result), .carry_out(alu_carry)
    );

    cpu_shift shifter (
        .value(a_reg), .carry_in(carry), .op(shift_op),
        .result(shift_result), .carry_out(shift_carry)
    );

    // Counter unit, plain pass for TXA and TYA
    assign count_in  = count_x ? x_reg : y_reg;
    assign count_out = count_in + {8{count_down}} + {7'd0, count_up};

    always_comb
    begin
        if (uses_alu)
            internal_bus = alu_result;
        else if (is_shift)
            internal_bus = shift_result;
        else if (transfer_from_a)
            internal_bus = a_reg;                          // TAX, TAY
        else if (count_x | count_y)
            internal_bus = count_out;
        else
            internal_bus = operand;                        // LDX, LDY
    end

    // SEC and CLC take bit 5 of the opcode
    assign next_carry = set_carry_direct ? opcode[5] :
                        uses_alu         ? alu_carry :
                        is_shift         ? shift_carry : carry;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
            carry <= 1'b0;
        end
        else if (execute)
        begin
            if (load_a) a_reg <= internal_bus;
            if (load_x) x_reg <= internal_bus;
            if (load_y) y_reg <= internal_bus;
            carry <= next_carry;                           // CMP lands here only
        end
    end

    // Store source by class bits
    always_comb
    begin
        case (opcode[1:0])
            2'b00:   store_data = y_reg;                   // STY
            2'b10:   store_data = x_reg;                   // STX
            default: store_data = a_reg;                   // STA
        endcase
    end

endmodule

/* rtl/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [cpu_pkg::data_width-1:0] data_in,
    input  logic                           is_two_cycle,
    input  logic                           is_zero_page,
    input  logic                           is_jump,
    input  logic                           is_store,
    input  logic [cpu_pkg::data_width-1:0] store_data,
    output logic [cpu_pkg::addr_width-1:0] address,
    output logic [cpu_pkg::data_width-1:0] data_out,
    output logic                           write_enable,
    output logic                           sync,
    output logic [cpu_pkg::data_width-1:0] opcode,
    output logic [cpu_pkg::data_width-1:0] operand,
    output logic                           execute
);

    cpu_pkg::cpu_state_e            state, next_state;
    logic [cpu_pkg::addr_width-1:0] pc, next_pc;

    // Cycle control
    always_comb
    begin
        next_state   = state;
        next_pc      = pc;
        address      = pc;
        write_enable = 1'b0;
        sync         = 1'b0;
        case (state)
            cpu_pkg::vector_low:
            begin
                address    = cpu_pkg::reset_vector;        // Low byte lands in operand
                next_state = cpu_pkg::vector_high;
            end
            cpu_pkg::vector_high:
            begin
                address    = cpu_pkg::reset_vector + 16'd1;
                next_pc    = {data_in, operand};
                next_state = cpu_pkg::fetch_opcode;
            end
            cpu_pkg::fetch_opcode:
            begin
                sync       = 1'b1;
                next_pc    = pc + 16'd1;
                next_state = cpu_pkg::fetch_operand;
            end
            cpu_pkg::fetch_operand:
            begin
                if (!is_two_cycle)
                    next_pc = pc + 16'd1;                  // Skip the operand byte
                if (is_zero_page)
                    next_state = cpu_pkg::zero_page_access;
                else if (is_jump)
                    next_state = cpu_pkg::fetch_high;
                else
                    next_state = cpu_pkg::fetch_opcode;    // Immediate, implied, accumulator
            end
            cpu_pkg::fetch_high:
            begin
                next_pc    = {data_in, operand};           // JMP target
                next_state = cpu_pkg::fetch_opcode;
            end
            cpu_pkg::zero_page_access:
            begin
                address      = {cpu_pkg::zero_page, operand};
                write_enable = is_store;
                next_state   = cpu_pkg::fetch_opcode;
            end
            default: next_state = cpu_pkg::vector_low;
        endcase
    end

    assign data_out = store_data;                          // Only sampled with write_enable
    assign execute  = enable & (state == cpu_pkg::fetch_opcode);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= cpu_pkg::vector_low;
            pc     <= cpu_pkg::reset_vector;
            opcode <= 8'h4c;                               // JMP abs, no datapath effect
        end
        else if (enable)
        begin
            state <= next_state;
            pc    <= next_pc;
            if (state == cpu_pkg::fetch_opcode)
                opcode <= data_in;
        end
    end

    // Registered data input, also the low byte for vector and JMP
    always_ff @(posedge clock)
    begin
        if (enable)
            operand <= data_in;
    end

endmodule

/* rtl/cpu_shift.sv */
`timescale 1ns/1ps

module cpu_shift (
    input  logic [cpu_pkg::data_width-1:0] value,
    input  logic                           carry_in,
    input  cpu_pkg::shift_op_e             op,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           carry_out
);

    logic rotate;
    logic right;
    logic fill;  // Bit entering the vacated end

    assign rotate = (op == cpu_pkg::op_rol) | (op == cpu_pkg::op_ror);
    assign right  = (op == cpu_pkg::op_lsr) | (op == cpu_pkg::op_ror);
    assign fill   = rotate & carry_in;

    always_comb
    begin
        if (right)
            {result, carry_out} = {fill, value};     // Bit 0 falls out
        else
            {carry_out, result} = {value, fill};     // Bit 7 falls out
    end

endmodule

/* rtl/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu (
    input  logic [cpu_pkg::data_width-1:0] a,
    input  logic [cpu_pkg::data_width-1:0] b,
    input  logic                           carry_in,
    input  cpu_pkg::alu_op_e               op,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           carry_out
);

    logic                           subtract;
    logic                           add_carry;
    logic [cpu_pkg::data_width-1:0] addend;
    logic [cpu_pkg::data_width:0]   sum;  // Carry in the top bit

    // CMP and SBC add the complement of b
    assign subtract  = (op == cpu_pkg::op_cmp) | (op == cpu_pkg::op_sbc);
    assign addend    = subtract ? ~b : b;
    assign add_carry = (op == cpu_pkg::op_cmp) | carry_in; // CMP always as A - b
    assign sum       = {1'b0, a} + {1'b0, addend} + {8'd0, add_carry};

    always_comb
    begin
        result    = a;
        carry_out = carry_in;                              // Logic ops keep carry
        case (op)
            cpu_pkg::op_ora: result = a | b;
            cpu_pkg::op_and: result = a & b;
            cpu_pkg::op_eor: result = a ^ b;
            cpu_pkg::op_lda: result = b;
            cpu_pkg::op_adc, cpu_pkg::op_sbc:
            begin
                result    = sum[cpu_pkg::data_width-1:0];
                carry_out = sum[cpu_pkg::data_width];      // Borrow inverted for SBC
            end
            cpu_pkg::op_cmp: carry_out = sum[cpu_pkg::data_width]; // Set when a >= b
            default: result = a;                           // STA never reads the ALU
        endcase
    end

endmodule

/* rtl/cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode (
    input  logic [cpu_pkg::data_width-1:0] opcode,
    output cpu_pkg::alu_op_e               alu_op,
    output cpu_pkg::shift_op_e             shift_op,
    output logic                           is_two_cycle,     // One-byte two-cycle form
    output logic                           is_zero_page,
    output logic                           is_jump,
    output logic                           is_store,
    output logic                           uses_alu,
    output logic                           is_shift,
    output logic                           load_a,
    output logic                           load_x,
    output logic                           load_y,
    output logic                           count_x,
    output logic                           count_y,
    output logic                           count_up,
    output logic                           count_down,
    output logic                           transfer_from_a,
    output logic                           set_carry_direct
);

    logic [2:0] group_field; // aaa
    logic [2:0] mode_field;  // bbb
    logic [1:0] class_field; // cc
    logic       implied;
    logic       inx, iny, dex, dey, txa, tya;

    assign group_field = opcode[7:5];
    assign mode_field  = opcode[4:2];
    assign class_field = opcode[1:0];

    assign alu_op   = cpu_pkg::alu_op_e'(opcode[7:5]);
    assign shift_op = cpu_pkg::shift_op_e'(opcode[6:5]);

    // Single-byte forms live in columns x10 with even class
    assign implied = (mode_field ==? 3'b?10) & ~class_field[0];

    // Register moves and counters, all xxx_x10_x0
    assign inx = (group_field == 3'b111) & (mode_field == 3'b010) & (class_field == 2'b00);
    assign iny = (group_field == 3'b110) & (mode_field == 3'b010) & (class_field == 2'b00);
    assign dex = (group_field == 3'b110) & (mode_field == 3'b010) & (class_field == 2'b10);
    assign dey = (group_field == 3'b100) & (mode_field == 3'b010) & (class_field == 2'b00);
    assign txa = (group_field == 3'b100) & (mode_field == 3'b010) & (class_field == 2'b10);
    assign tya = (group_field == 3'b100) & (mode_field == 3'b110) & (class_field == 2'b00);

    // Sequencer classes; immediate is the fall-through
    assign is_two_cycle = implied;                     // No operand byte, PC holds
    assign is_zero_page = (mode_field == 3'b001);
    assign is_jump      = (group_field == 3'b010) & (mode_field == 3'b011) & (class_field == 2'b00);
    assign is_store     = (group_field == 3'b100) & (mode_field == 3'b001); // STY STA STX

    // Datapath selects
    assign uses_alu         = (class_field == 2'b01) & (group_field != 3'b100);
    assign is_shift         = ~group_field[2] & (mode_field == 3'b010) & (class_field == 2'b10);
    assign transfer_from_a  = (group_field == 3'b101) & (mode_field == 3'b010) & ~class_field[0];
    assign set_carry_direct = (group_field[2:1] == 2'b00) & (mode_field == 3'b110)
                              & (class_field == 2'b00);    // CLC, SEC

    assign load_a  = (uses_alu & (group_field != 3'b110)) | is_shift | txa | tya; // Not CMP
    assign load_x  = ((group_field == 3'b101) & (class_field == 2'b10)) | inx | dex; // LDX TAX
    assign load_y  = ((group_field == 3'b101) & (class_field == 2'b00)) | iny | dey; // LDY TAY

    assign count_x    = txa | inx | dex;
    assign count_y    = tya | iny | dey;
    assign count_up   = inx | iny;
    assign count_down = dex | dey;

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // Bus and register sizes
    localparam int data_width = 8;  // Data bus, A, X, Y
    localparam int addr_width = 16; // Address bus and PC

    // Low byte of the start address; the high byte sits at the next address
    localparam logic [addr_width-1:0] reset_vector = 16'hfffc;

    // High address byte for zero-page reads and stores
    localparam logic [data_width-1:0] zero_page = 8'h00;

    // Bus cycle states
    typedef enum logic [2:0] {
        vector_low       = 3'd0, // Read FFFC
        vector_high      = 3'd1, // Read FFFD, load PC
        fetch_opcode     = 3'd2, // Opcode read, previous result committed
        fetch_operand    = 3'd3, // Second instruction byte
        fetch_high       = 3'd4, // Third byte of JMP absolute
        zero_page_access = 3'd5  // Read or write at 00xx
    } cpu_state_e;

    // ALU group, opcode bits 7 to 5
    typedef enum logic [2:0] {
        op_ora = 3'd0,
        op_and = 3'd1,
        op_eor = 3'd2,
        op_adc = 3'd3,
        op_sta = 3'd4, // Store, ALU result unused
        op_lda = 3'd5, // Pass operand
        op_cmp = 3'd6, // Carry only
        op_sbc = 3'd7
    } alu_op_e;

    // Shift group, opcode bits 6 to 5
    typedef enum logic [1:0] {
        op_asl = 2'd0,
        op_rol = 2'd1,
        op_lsr = 2'd2,
        op_ror = 2'd3
    } shift_op_e;

endpackage
